//--- rtl/genesis_macros.svh
// Fixed addresses and constants of the cartridge host glue.
// Included by every module that decodes the bridge or the ROM stream.

`ifndef GENESIS_MACROS_SVH
`define GENESIS_MACROS_SVH

// core settings written by the host
`define CS_ADDR_MULTITAP       32'h0000_0000
`define CS_ADDR_AR_CORRECTION  32'h0000_0010
`define CS_ADDR_COMPOSITE      32'h0000_0020
`define CS_ADDR_OBJ_LIMIT      32'h0000_0030
`define CS_ADDR_FM_ENABLE      32'h0000_0040
`define CS_ADDR_PSG_ENABLE     32'h0000_0050
`define CS_ADDR_HIFI_PCM       32'h0000_0060
`define CS_ADDR_RESET          32'h0000_0070
`define CS_ADDR_FM_CHIP        32'h00A0_0000
`define CS_ADDR_TURBO          32'h00C0_0000
`define CS_ADDR_FILTER         32'h00F0_0000

// bridge regions
`define REGION_READ_ADDR       32'h00E0_0000
`define ROM_REGION_NIBBLE      4'h1   // addr[31:28] of ROM data

// cartridge header, ROM byte offsets
`define HDR_REGION_ADDR        25'h1F0
`define HDR_REGION2_ADDR       25'h1F2
`define HDR_END_ADDR           25'h200
`define ID_ADDR_FIRST          25'h182
`define ID_ADDR_CHECK          25'h18C

`define CORE_RESET_HOLD_CYCLES 64
`define GUN_DELAY_DEFAULT      8'd44
`define PAD_SYNC_STAGES        3

`endif

//--- rtl/genesis_pkg.sv
// Shared types for the cartridge host glue on the bridge clock.
// Modules name these in their port lists as genesis_pkg::type and
// import the package inside the body when they use it there.

package genesis_pkg;

	// bridge bus
	typedef logic [31:0] bridge_addr_t;
	typedef logic [31:0] bridge_data_t;

	// ROM halfword stream from the download path
	typedef logic [24:0] rom_addr_t;  // byte address of a halfword
	typedef logic [15:0] rom_half_t;

	// pads
	typedef logic [15:0] cont_key_t;    // host key bitmap
	typedef logic [11:0] console_pad_t; // Z Y X mode start B C A up down left right

	typedef logic [1:0] region_t;       // 0 japan, 1 us, 2 europe

	// cartridge quirks
	typedef logic [8:0] quirk_flags_t;
	typedef enum logic [3:0] {
		quirk_fifo,
		quirk_eeprom,
		quirk_sram,
		quirk_sram00,
		quirk_noram,
		quirk_pier,
		quirk_svp,
		quirk_fmbusy,
		quirk_schan
	} quirk_bit_e;

	typedef logic [7:0] gun_delay_t;

endpackage

//--- rtl/core_regs.sv
// Core settings registers written over the bridge, the reset-hold
// timer and the bridge read-data selection. Drives system_reset_n
// for the console from the timer and the region update strobe.

`timescale 1ns/1ps
`include "genesis_macros.svh"

module core_regs (
	input  logic                      clk_74a,
	input  logic                      pll_core_locked,
	input  genesis_pkg::bridge_addr_t bridge_addr,
	input  logic                      bridge_wr,
	input  genesis_pkg::bridge_data_t bridge_wr_data,
	output genesis_pkg::bridge_data_t bridge_rd_data,
	input  logic                      osnotify_inmenu,
	input  genesis_pkg::region_t      region_req,
	input  logic                      region_set,
	output logic                      system_reset_n,
	output logic [1:0]                cpu_turbo,
	output logic                      multitap_enable,
	output logic                      ar_correction_enable,
	output logic                      composite_enable,
	output logic                      obj_limit_high_enable,
	output logic                      fm_enable,
	output logic                      psg_enable,
	output logic                      hifi_pcm_enable,
	output logic [1:0]                audio_filter,
	output logic                      fm_chip
);

	localparam int hold_w = $clog2(`CORE_RESET_HOLD_CYCLES + 1);

	logic [hold_w-1:0] hold_cnt; // reset-hold countdown
	logic              core_run; // low only while pll_core_locked is low

	//////////////////////////////////////////////////////////////////////
	// settings and reset hold

	always_ff @(posedge clk_74a or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			core_run              <= 1'b0;
			hold_cnt              <= '0;
			cpu_turbo             <= 2'd0;
			multitap_enable       <= 1'b0;
			ar_correction_enable  <= 1'b0;
			composite_enable      <= 1'b0;
			obj_limit_high_enable <= 1'b1;
			fm_enable             <= 1'b1;
			psg_enable            <= 1'b1;
			hifi_pcm_enable       <= 1'b1;
			audio_filter          <= 2'd0;
			fm_chip               <= 1'b0;
		end else begin
			core_run <= 1'b1;
			// timer freezes while the host menu is up
			if (!osnotify_inmenu && hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;

			if (bridge_wr) begin
				case (bridge_addr)
					`CS_ADDR_MULTITAP:      multitap_enable       <= bridge_wr_data[0];
					`CS_ADDR_AR_CORRECTION: ar_correction_enable  <= bridge_wr_data[0];
					`CS_ADDR_COMPOSITE:     composite_enable      <= bridge_wr_data[0];
					`CS_ADDR_OBJ_LIMIT:     obj_limit_high_enable <= bridge_wr_data[0];
					`CS_ADDR_FM_ENABLE:     fm_enable             <= bridge_wr_data[0];
					`CS_ADDR_PSG_ENABLE:    psg_enable            <= bridge_wr_data[0];
					`CS_ADDR_HIFI_PCM:      hifi_pcm_enable       <= bridge_wr_data[0];
					`CS_ADDR_FM_CHIP:       fm_chip               <= bridge_wr_data[0];
					`CS_ADDR_TURBO:         cpu_turbo             <= bridge_wr_data[1:0];
					`CS_ADDR_FILTER:        audio_filter          <= bridge_wr_data[1:0];
					`CS_ADDR_RESET: begin
						if (bridge_wr_data != '0)
							hold_cnt <= hold_w'(`CORE_RESET_HOLD_CYCLES);
					end
					default: ;
				endcase
			end
		end
	end

	// console held while the timer runs or a new region is applied
	assign system_reset_n = core_run && (hold_cnt == '0) && !region_set;

	//////////////////////////////////////////////////////////////////////
	// read data, no latency

	assign bridge_rd_data = (bridge_addr == `REGION_READ_ADDR) ? {30'd0, region_req} : '0;

endmodule

//--- rtl/rom_word_unpacker.sv
// Tracks the ROM download window and turns each 32-bit bridge write
// into the ROM region into two 16-bit writes, high halfword first.

`timescale 1ns/1ps
`include "genesis_macros.svh"

module rom_word_unpacker (
	input  logic                      clk_74a,
	input  logic                      pll_core_locked,
	input  genesis_pkg::bridge_addr_t bridge_addr,
	input  logic                      bridge_wr,
	input  genesis_pkg::bridge_data_t bridge_wr_data,
	input  logic                      dataslot_requestwrite,
	input  logic                      dataslot_allcomplete,
	output logic                      rom_download,
	output logic                      download_start,
	output logic                      rom_wr,
	output genesis_pkg::rom_addr_t    rom_addr,
	output genesis_pkg::rom_half_t    rom_data
);

	import genesis_pkg::*;

	typedef enum logic {unp_idle, unp_low} unp_state_e;

	unp_state_e state;
	rom_half_t  low_half; // second halfword waiting its turn
	logic       accept;

	assign accept = bridge_wr && rom_download && (bridge_addr[31:28] == `ROM_REGION_NIBBLE);

	always_ff @(posedge clk_74a or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			rom_download   <= 1'b0;
			download_start <= 1'b0;
			state          <= unp_idle;
			rom_wr         <= 1'b0;
		end else begin
			download_start <= dataslot_requestwrite && !rom_download;
			if (dataslot_requestwrite)
				rom_download <= 1'b1;
			else if (dataslot_allcomplete)
				rom_download <= 1'b0;

			rom_wr <= accept || (state == unp_low);
			state  <= accept ? unp_low : unp_idle;
		end
	end

	// halfword payload, big-endian order
	always_ff @(posedge clk_74a) begin
		if (accept) begin
			rom_addr <= bridge_addr[24:0];
			rom_data <= bridge_wr_data[31:16];
			low_half <= bridge_wr_data[15:0];
		end else if (state == unp_low) begin
			rom_addr <= rom_addr + 25'd2;
			rom_data <= low_half;
		end
	end

endmodule

//--- rtl/cart_region_detect.sv
// Watches the ROM halfword stream for the header region string and
// picks the console region once the header has passed. region_set
// stays high from then until the next download starts.

`timescale 1ns/1ps
`include "genesis_macros.svh"

module cart_region_detect (
	input  logic                   clk_74a,
	input  logic                   pll_core_locked,
	input  logic                   download_start,
	input  logic                   rom_wr,
	input  genesis_pkg::rom_addr_t rom_addr,
	input  genesis_pkg::rom_half_t rom_data,
	output genesis_pkg::region_t   region_req,
	output logic                   region_set
);

	logic [2:0] hdr_flags; // {e, u, j}
	logic       hdr_ready;
	logic       old_ready;
	logic [7:0] lo_byte;
	logic [7:0] hi_byte;
	logic       lo_is_hex;
	logic [3:0] hex_val;

	// one-hot {e, u, j} for a region letter
	function automatic logic [2:0] letter_mask(input logic [7:0] c);
		case (c)
			"J":     return 3'b001;
			"U":     return 3'b010;
			"E":     return 3'b100;
			default: return 3'b000;
		endcase
	endfunction

	assign lo_byte   = rom_data[7:0];
	assign hi_byte   = rom_data[15:8];
	assign lo_is_hex = (lo_byte >= "0" && lo_byte <= "9") || (lo_byte >= "A" && lo_byte <= "F");
	assign hex_val   = (lo_byte <= "9") ? lo_byte[3:0] : lo_byte[3:0] - 4'd7;

	always_ff @(posedge clk_74a or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			hdr_flags <= 3'b000;
			hdr_ready <= 1'b0;
		end else if (download_start) begin
			hdr_flags <= 3'b000;
			hdr_ready <= 1'b0;
		end else if (rom_wr) begin
			if (rom_addr == `HDR_REGION_ADDR) begin
				if (lo_is_hex && letter_mask(lo_byte) == 3'b000)
					hdr_flags <= {hex_val[3], hex_val[2], hex_val[0]} | letter_mask(hi_byte);
				else
					hdr_flags <= hdr_flags | letter_mask(lo_byte) | letter_mask(hi_byte);
			end
			if (rom_addr == `HDR_REGION2_ADDR)
				hdr_flags <= hdr_flags | letter_mask(lo_byte);
			if (rom_addr == `HDR_END_ADDR)
				hdr_ready <= 1'b1;
		end
	end

	// region priority U, E, J, default US
	always_ff @(posedge clk_74a or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			old_ready  <= 1'b0;
			region_req <= 2'd0;
			region_set <= 1'b0;
		end else begin
			old_ready <= hdr_ready;
			if (download_start) begin
				region_set <= 1'b0;
			end else if (hdr_ready && !old_ready) begin
				region_set <= 1'b1;
				if (hdr_flags[1])      region_req <= 2'd1;
				else if (hdr_flags[2]) region_req <= 2'd2;
				else if (hdr_flags[0]) region_req <= 2'd0;
				else                   region_req <= 2'd1;
			end
		end
	end

endmodule

//--- rtl/cart_quirk_detect.sv
// Builds the 8-character cartridge ID from the ROM header and looks
// it up in the known-title table. Flags and lightgun timing change
// on the cycle after the halfword at ID_ADDR_CHECK is written.

`timescale 1ns/1ps
`include "genesis_macros.svh"

module cart_quirk_detect (
	input  logic                      clk_74a,
	input  logic                      pll_core_locked,
	input  logic                      download_start,
	input  logic                      rom_wr,
	input  genesis_pkg::rom_addr_t    rom_addr,
	input  genesis_pkg::rom_half_t    rom_data,
	output genesis_pkg::quirk_flags_t quirk_flags,
	output logic                      gun_type,
	output genesis_pkg::gun_delay_t   gun_sensor_delay
);

	import genesis_pkg::*;

	logic [63:0] cart_id; // ascii, first character in the top byte

	// ID spans 0x182..0x18B, first and last halfwords only half used
	always_ff @(posedge clk_74a) begin
		if (rom_wr) begin
			case (rom_addr)
				`ID_ADDR_FIRST:          cart_id[63:56] <= rom_data[15:8];
				`ID_ADDR_FIRST + 25'd2:  cart_id[55:40] <= {rom_data[7:0], rom_data[15:8]};
				`ID_ADDR_FIRST + 25'd4:  cart_id[39:24] <= {rom_data[7:0], rom_data[15:8]};
				`ID_ADDR_FIRST + 25'd6:  cart_id[23:8]  <= {rom_data[7:0], rom_data[15:8]};
				`ID_ADDR_FIRST + 25'd8:  cart_id[7:0]   <= rom_data[7:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_74a or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			quirk_flags      <= '0;
			gun_type         <= 1'b0;
			gun_sensor_delay <= `GUN_DELAY_DEFAULT;
		end else if (download_start) begin
			quirk_flags <= '0;
		end else if (rom_wr && rom_addr == `ID_ADDR_CHECK) begin
			case (cart_id)
				"T-081276": quirk_flags[quirk_sram]   <= 1'b1;
				"MK-1215 ": quirk_flags[quirk_eeprom] <= 1'b1;
				"T-113016": quirk_flags[quirk_noram]  <= 1'b1; // fake ram check
				"T-89016 ": quirk_flags[quirk_fifo]   <= 1'b1;
				"MK-1229 ": quirk_flags[quirk_svp]    <= 1'b1;
				"T-35036 ": quirk_flags[quirk_fmbusy] <= 1'b1;
				default: ;
			endcase

			// lightgun device and sensor offset
			case (cart_id)
				"T-95096-": begin
					gun_type         <= 1'b1;
					gun_sensor_delay <= 8'd52;
				end
				"MK-1533 ": begin
					gun_type         <= 1'b0;
					gun_sensor_delay <= 8'd100;
				end
				default: begin
					gun_type         <= 1'b0;
					gun_sensor_delay <= `GUN_DELAY_DEFAULT;
				end
			endcase
		end
	end

endmodule

//--- rtl/pad_remap.sv
// Synchronizes the four host key maps and reorders their bits into
// the 12-button console pad layout.

`timescale 1ns/1ps
`include "genesis_macros.svh"

module pad_remap (
	input  logic                      clk_74a,
	input  logic                      pll_core_locked,
	input  genesis_pkg::cont_key_t    cont1_key,
	input  genesis_pkg::cont_key_t    cont2_key,
	input  genesis_pkg::cont_key_t    cont3_key,
	input  genesis_pkg::cont_key_t    cont4_key,
	output genesis_pkg::console_pad_t joy_0,
	output genesis_pkg::console_pad_t joy_1,
	output genesis_pkg::console_pad_t joy_2,
	output genesis_pkg::console_pad_t joy_3
);

	import genesis_pkg::*;

	localparam int stages = `PAD_SYNC_STAGES;

	cont_key_t key_in [4];
	cont_key_t sync_q [4][stages];

	// Z Y X mode start B C A up down left right
	function automatic console_pad_t remap(input cont_key_t k);
		return {k[9], k[6], k[8], k[14], k[15], k[4], k[5], k[7], k[0], k[1], k[2], k[3]};
	endfunction

	assign key_in[0] = cont1_key;
	assign key_in[1] = cont2_key;
	assign key_in[2] = cont3_key;
	assign key_in[3] = cont4_key;

	always_ff @(posedge clk_74a or negedge pll_core_locked) begin
		if (!pll_core_locked) begin
			for (int p = 0; p < 4; p++)
				for (int s = 0; s < stages; s++)
					sync_q[p][s] <= '0;
		end else begin
			for (int p = 0; p < 4; p++) begin
				sync_q[p][0] <= key_in[p];
				for (int s = 1; s < stages; s++)
					sync_q[p][s] <= sync_q[p][s-1];
			end
		end
	end

	assign joy_0 = remap(sync_q[0][stages-1]);
	assign joy_1 = remap(sync_q[1][stages-1]);
	assign joy_2 = remap(sync_q[2][stages-1]);
	assign joy_3 = remap(sync_q[3][stages-1]);

endmodule

//--- rtl/genesis_core_top.sv
// Top level of the cartridge host glue on clk_74a. The host bridge
// bus is broadcast to every block; only core_regs answers reads.

`timescale 1ns/1ps

module genesis_core_top (
	input  logic                      clk_74a,
	input  logic                      pll_core_locked,
	// bridge bus from the host
	input  genesis_pkg::bridge_addr_t bridge_addr,
	input  logic                      bridge_rd,
	output genesis_pkg::bridge_data_t bridge_rd_data,
	input  logic                      bridge_wr,
	input  genesis_pkg::bridge_data_t bridge_wr_data,
	output logic                      bridge_endian_little,
	// host notifications
	input  logic                      dataslot_requestwrite,
	input  logic                      dataslot_allcomplete,
	input  logic                      osnotify_inmenu,
	input  genesis_pkg::cont_key_t    cont1_key,
	input  genesis_pkg::cont_key_t    cont2_key,
	input  genesis_pkg::cont_key_t    cont3_key,
	input  genesis_pkg::cont_key_t    cont4_key,
	// to the console
	output logic                      system_reset_n,
	output logic [1:0]                cpu_turbo,
	output logic                      multitap_enable,
	output logic                      ar_correction_enable,
	output logic                      composite_enable,
	output logic                      obj_limit_high_enable,
	output logic                      fm_enable,
	output logic                      psg_enable,
	output logic                      hifi_pcm_enable,
	output logic [1:0]                audio_filter,
	output logic                      fm_chip,
	output genesis_pkg::quirk_flags_t quirk_flags,
	output logic                      gun_type,
	output genesis_pkg::gun_delay_t   gun_sensor_delay,
	output genesis_pkg::console_pad_t joy_0,
	output genesis_pkg::console_pad_t joy_1,
	output genesis_pkg::console_pad_t joy_2,
	output genesis_pkg::console_pad_t joy_3
);

	import genesis_pkg::*;

	// ROM halfword stream, snooped by both detectors
	logic      download_start;
	logic      rom_wr;
	rom_addr_t rom_addr;
	rom_half_t rom_data;
	region_t   region_req;
	logic      region_set;

	assign bridge_endian_little = 1'b0; // bridge words are big-endian

	//////////////////////////////////////////////////////////////////////

	core_regs u_core_regs (
		.clk_74a               (clk_74a),
		.pll_core_locked       (pll_core_locked),
		.bridge_addr           (bridge_addr),
		.bridge_wr             (bridge_wr),
		.bridge_wr_data        (bridge_wr_data),
		.bridge_rd_data        (bridge_rd_data),
		.osnotify_inmenu       (osnotify_inmenu),
		.region_req            (region_req),
		.region_set            (region_set),
		.system_reset_n        (system_reset_n),
		.cpu_turbo             (cpu_turbo),
		.multitap_enable       (multitap_enable),
		.ar_correction_enable  (ar_correction_enable),
		.composite_enable      (composite_enable),
		.obj_limit_high_enable (obj_limit_high_enable),
		.fm_enable             (fm_enable),
		.psg_enable            (psg_enable),
		.hifi_pcm_enable       (hifi_pcm_enable),
		.audio_filter          (audio_filter),
		.fm_chip               (fm_chip)
	);

	rom_word_unpacker u_rom_word_unpacker (
		.clk_74a               (clk_74a),
		.pll_core_locked       (pll_core_locked),
		.bridge_addr           (bridge_addr),
		.bridge_wr             (bridge_wr),
		.bridge_wr_data        (bridge_wr_data),
		.dataslot_requestwrite (dataslot_requestwrite),
		.dataslot_allcomplete  (dataslot_allcomplete),
		.rom_download          (),
		.download_start        (download_start),
		.rom_wr                (rom_wr),
		.rom_addr              (rom_addr),
		.rom_data              (rom_data)
	);

	cart_region_detect u_cart_region_detect (
		.clk_74a         (clk_74a),
		.pll_core_locked (pll_core_locked),
		.download_start  (download_start),
		.rom_wr          (rom_wr),
		.rom_addr        (rom_addr),
		.rom_data        (rom_data),
		.region_req      (region_req),
		.region_set      (region_set)
	);

	cart_quirk_detect u_cart_quirk_detect (
		.clk_74a          (clk_74a),
		.pll_core_locked  (pll_core_locked),
		.download_start   (download_start),
		.rom_wr           (rom_wr),
		.rom_addr         (rom_addr),
		.rom_data         (rom_data),
		.quirk_flags      (quirk_flags),
		.gun_type         (gun_type),
		.gun_sensor_delay (gun_sensor_delay)
	);

	pad_remap u_pad_remap (
		.clk_74a         (clk_74a),
		.pll_core_locked (pll_core_locked),
		.cont1_key       (cont1_key),
		.cont2_key       (cont2_key),
		.cont3_key       (cont3_key),
		.cont4_key       (cont4_key),
		.joy_0           (joy_0),
		.joy_1           (joy_1),
		.joy_2           (joy_2),
		.joy_3           (joy_3)
	);

endmodule

//--- testbench/tb_genesis_core.sv
// Vector-driven testbench for the cartridge host glue. Each record of
// the vector file drives the bridge, the host strobes or a pad, or checks
// an output group against the expected value stored with it.
// Run from the project root so the vector path resolves.

`timescale 1ns/1ps
`include "genesis_macros.svh"

module tb_genesis_core;

	import genesis_pkg::*;

	localparam int max_rec = 128;

	// record opcodes
	localparam logic [31:0] op_end      = 32'd0;
	localparam logic [31:0] op_write    = 32'd1;
	localparam logic [31:0] op_read     = 32'd2;
	localparam logic [31:0] op_dl_begin = 32'd3;
	localparam logic [31:0] op_dl_end   = 32'd4;
	localparam logic [31:0] op_pad      = 32'd5;
	localparam logic [31:0] op_check    = 32'd6;
	localparam logic [31:0] op_menu     = 32'd7;
	localparam logic [31:0] op_idle     = 32'd8;
	localparam logic [31:0] op_release  = 32'd9;

	logic         clk_74a;
	logic         pll_core_locked;
	bridge_addr_t bridge_addr;
	logic         bridge_rd;
	bridge_data_t bridge_rd_data;
	logic         bridge_wr;
	bridge_data_t bridge_wr_data;
	logic         bridge_endian_little;
	logic         dataslot_requestwrite;
	logic         dataslot_allcomplete;
	logic         osnotify_inmenu;
	cont_key_t    cont1_key;
	cont_key_t    cont2_key;
	cont_key_t    cont3_key;
	cont_key_t    cont4_key;
	logic         system_reset_n;
	logic [1:0]   cpu_turbo;
	logic         multitap_enable;
	logic         ar_correction_enable;
	logic         composite_enable;
	logic         obj_limit_high_enable;
	logic         fm_enable;
	logic         psg_enable;
	logic         hifi_pcm_enable;
	logic [1:0]   audio_filter;
	logic         fm_chip;
	quirk_flags_t quirk_flags;
	logic         gun_type;
	gun_delay_t   gun_sensor_delay;
	console_pad_t joy_0;
	console_pad_t joy_1;
	console_pad_t joy_2;
	console_pad_t joy_3;

	logic [31:0] vec [0:4*max_rec-1]; // op, addr, data, expected per record
	int          rec_count;
	int          rec_idx;
	int          fail_count  = 0;
	int          cycle_cnt   = 0;
	int          cycle_limit = 200;
	logic [11:0] settings_now;
	logic [17:0] quirk_now;

	// packed views of the output groups that records check
	assign settings_now = {cpu_turbo, multitap_enable, ar_correction_enable, composite_enable,
		obj_limit_high_enable, fm_enable, psg_enable, hifi_pcm_enable, audio_filter, fm_chip};
	assign quirk_now = {gun_type, gun_sensor_delay, quirk_flags};

	genesis_core_top u_genesis_core_top (.*);

	always #2 clk_74a = ~clk_74a;

	always @(posedge clk_74a) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, the vector records did not finish", cycle_cnt);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			fail_count++;
			$display("Fail at %0t ns: record %0d %s is %h, expected %h",
				$time, rec_idx, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk_74a);
		bridge_addr    <= addr;
		bridge_wr_data <= data;
		bridge_wr      <= 1'b1;
		@(posedge clk_74a);
		bridge_wr <= 1'b0;
		repeat (3) @(posedge clk_74a); // host write spacing
	endtask

	task automatic bus_read_check(input logic [31:0] addr, input logic [31:0] exp);
		@(posedge clk_74a);
		bridge_addr <= addr;
		bridge_rd   <= 1'b1;
		@(negedge clk_74a);
		check_value(bridge_rd_data, exp, "bridge read data");
		@(posedge clk_74a);
		bridge_rd <= 1'b0;
	endtask

	// one-cycle strobe of requestwrite or of allcomplete when done is set
	task automatic dataslot_pulse(input logic done);
		@(posedge clk_74a);
		if (done)
			dataslot_allcomplete <= 1'b1;
		else
			dataslot_requestwrite <= 1'b1;
		@(posedge clk_74a);
		dataslot_allcomplete  <= 1'b0;
		dataslot_requestwrite <= 1'b0;
		repeat (3) @(posedge clk_74a);
	endtask

	task automatic apply_keys(input logic [31:0] pad, input logic [31:0] key,
		input logic [31:0] exp);
		console_pad_t got;
		@(posedge clk_74a);
		case (pad)
			0: cont1_key <= key[15:0];
			1: cont2_key <= key[15:0];
			2: cont3_key <= key[15:0];
			default: cont4_key <= key[15:0];
		endcase
		repeat (`PAD_SYNC_STAGES + 1) @(posedge clk_74a);
		@(negedge clk_74a);
		case (pad)
			0: got = joy_0;
			1: got = joy_1;
			2: got = joy_2;
			default: got = joy_3;
		endcase
		check_value({20'd0, got}, exp, "pad output");
	endtask

	task automatic check_outputs(input logic [31:0] group, input logic [31:0] exp);
		@(negedge clk_74a);
		case (group)
			0: check_value({20'd0, settings_now}, exp, "settings");
			1: check_value({14'd0, quirk_now}, exp, "quirk and lightgun");
			default: check_value({31'd0, system_reset_n}, exp, "system_reset_n");
		endcase
	endtask

	// polls at the falling edge until the console leaves reset
	task automatic wait_reset_release(input logic [31:0] limit);
		int n;
		n = 0;
		@(negedge clk_74a);
		while (system_reset_n !== 1'b1 && n < limit) begin
			@(negedge clk_74a);
			n++;
		end
		check_value({31'd0, system_reset_n}, 32'd1, "system_reset_n release");
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
		clk_74a               = 1'b0;
		pll_core_locked       = 1'b0;
		bridge_addr           = '0;
		bridge_rd             = 1'b0;
		bridge_wr             = 1'b0;
		bridge_wr_data        = '0;
		dataslot_requestwrite = 1'b0;
		dataslot_allcomplete  = 1'b0;
		osnotify_inmenu       = 1'b0;
		cont1_key             = '0;
		cont2_key             = '0;
		cont3_key             = '0;
		cont4_key             = '0;

		for (int i = 0; i < 4*max_rec; i++)
			vec[i] = '0;
		$readmemh("testbench/genesis_vectors.mem", vec);
		rec_count = 0;
		while (rec_count < max_rec && vec[4*rec_count] != op_end)
			rec_count++;
		if (rec_count == 0) begin
			$display("the vector file is missing or holds no records");
			$display("SIMULATION FAILED");
			$fatal(1, "no vectors");
		end
		cycle_limit = 8*rec_count + 200;

		repeat (2) @(posedge clk_74a);
		pll_core_locked <= 1'b1;
		@(posedge clk_74a);
		@(negedge clk_74a);
		check_value({31'd0, bridge_endian_little}, 32'd0, "bridge_endian_little");

		for (rec_idx = 0; rec_idx < rec_count; rec_idx++) begin
			op   = vec[4*rec_idx];
			addr = vec[4*rec_idx+1];
			data = vec[4*rec_idx+2];
			exp  = vec[4*rec_idx+3];
			case (op)
				op_write:    bus_write(addr, data);
				op_read:     bus_read_check(addr, exp);
				op_dl_begin: dataslot_pulse(1'b0);
				op_dl_end:   dataslot_pulse(1'b1);
				op_pad:      apply_keys(addr, data, exp);
				op_check:    check_outputs(addr, exp);
				op_menu: begin
					@(posedge clk_74a);
					osnotify_inmenu <= data[0];
				end
				op_idle:     repeat (data) @(posedge clk_74a);
				op_release:  wait_reset_release(data);
				default: begin
					$display("record %0d has the unknown opcode %h", rec_idx, op);
					$display("SIMULATION FAILED");
					$fatal(1, "bad vector record");
				end
			endcase
		end

		// a held nonzero region must not leak onto other read addresses
		bus_read_check(`CS_ADDR_AR_CORRECTION, 32'd0);

		repeat (4) @(posedge clk_74a);
		if (fail_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- testbench/genesis_vectors.mem
// columns: opcode address data expected, all hex
// op 1 write, 2 read check, 3/4 download begin/end, 5 pad keys, 6 check group
// (0 settings, 1 quirk, 2 reset), 7 menu, 8 idle, 9 wait reset release, 0 end
6 0 0 78
6 2 0 1
6 1 0 5800
2 00E00000 0 0
2 00000010 0 0
// settings, one address at a time
1 00000000 3 0
6 0 0 278
1 00000010 1 0
6 0 0 378
1 00000020 FFFFFFFF 0
6 0 0 3F8
1 00000030 2 0
6 0 0 3B8
1 00000040 FFFFFFFE 0
6 0 0 398
1 00000050 0 0
6 0 0 388
1 00000060 10 0
6 0 0 380
1 00A00000 1 0
6 0 0 381
1 00C00000 6 0
6 0 0 B81
1 00F00000 7 0
6 0 0 B87
// reset hold, frozen while the menu is up
1 00000070 0 0
6 2 0 1
7 0 1 0
1 00000070 5 0
6 2 0 0
8 0 46 0
6 2 0 0
7 0 0 0
9 0 45 0
// T-081276 sram, region JU
3 0 0 0
1 10000180 20205420 0
1 10000184 302D3138 0
1 10000188 37322036 0
1 1000018C 0 0
1 100001F0 4A554520 0
1 10000200 0 0
4 0 0 0
6 1 0 5804
6 2 0 0
2 00E00000 0 1
// MK-1533 lightgun, hex digit 1
3 0 0 0
6 2 0 1
1 10000180 20204D20 0
1 10000184 2D4B3531 0
1 10000188 33332020 0
1 1000018C 0 0
1 100001F0 20312020 0
1 10000200 0 0
4 0 0 0
6 1 0 C800
6 2 0 0
2 00E00000 0 0
// unlisted ID, blank region
3 0 0 0
1 10000180 20205420 0
1 10000184 302D3030 0
1 10000188 30302020 0
1 1000018C 0 0
1 100001F0 20202020 0
1 10000200 0 0
4 0 0 0
6 1 0 5800
6 2 0 0
2 00E00000 0 1
// T-95096- lightgun, E in second region halfword
3 0 0 0
1 10000180 20205420 0
1 10000184 392D3035 0
1 10000188 3639202D 0
1 1000018C 0 0
1 100001F0 20202045 0
1 10000200 0 0
4 0 0 0
6 1 0 26800
6 2 0 0
2 00E00000 0 2
// writes outside the ROM region, then outside the window
3 0 0 0
6 2 0 1
1 10000180 20205420 0
1 10000184 302D3138 0
1 10000188 37322036 0
1 2000018C 0 0
1 20000200 0 0
6 1 0 26800
6 2 0 1
4 0 0 0
1 1000018C 0 0
1 10000200 0 0
6 1 0 26800
6 2 0 1
2 00E00000 0 2
// pads
5 0 0001 008
5 1 8000 080
5 2 0350 E40
5 3 40AE 137
5 0 3C00 000
0 0 0 0

//--- verilog.f
+incdir+rtl
rtl/genesis_pkg.sv
rtl/core_regs.sv
rtl/rom_word_unpacker.sv
rtl/cart_region_detect.sv
rtl/cart_quirk_detect.sv
rtl/pad_remap.sv
rtl/genesis_core_top.sv
testbench/tb_genesis_core.sv

//--- Makefile
TOP = tb_genesis_core

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
